//--- Bender.yml
package:
  name: mdu

export_include_dirs:
  - verilog

sources:
  - verilog/mdu_pkg.sv
  - verilog/mdu_multiplier.sv
  - verilog/mdu_divider.sv
  - verilog/mdu.sv
  - target: test
    files:
      - test/mdu_tb.sv

//--- compile.f
+incdir+verilog
verilog/mdu_pkg.sv
verilog/mdu_multiplier.sv
verilog/mdu_divider.sv
verilog/mdu.sv
test/mdu_tb.sv

//--- test/mdu_tb.sv
`timescale 1ns/10ps
`include "mdu_defines.svh"

module mdu_tb
    import mdu_pkg::*;
();

    localparam int WAIT_LIMIT = 200;
    localparam int DIV_LAT    = `MDU_DIV_STEPS + 2;
    localparam int MUL_LAT    = 2;

    logic      clk;
    logic      rst_i;
    logic      flush_i;
    logic      valid_i;
    logic      ready_o;
    mdu_op_t   op_i;
    word_t     src_a_i;
    word_t     src_b_i;
    mdu_info_t info_i;
    logic      valid_o;
    logic      ready_i;
    word_t     result_o;
    mdu_info_t info_o;

    logic [31:0] rng_state;

    // Expected responses in request order
    word_t     exp_result_q[$];
    mdu_info_t exp_info_q[$];

    mdu u_mdu (
        .clk      (clk),
        .rst_i    (rst_i),
        .flush_i  (flush_i),
        .valid_i  (valid_i),
        .ready_o  (ready_o),
        .op_i     (op_i),
        .src_a_i  (src_a_i),
        .src_b_i  (src_b_i),
        .info_i   (info_i),
        .valid_o  (valid_o),
        .ready_i  (ready_i),
        .result_o (result_o),
        .info_o   (info_o)
    );

    always #10 clk = ~clk;

    // ==================================================================
    // Helpers
    // ==================================================================

    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic mdu_info_t random_info();
        logic [31:0] r;
        mdu_info_t   info;
        r       = next_rand();
        info.rd = r[4:0];
        info.we = r[5];
        info.pc = next_rand();
        return info;
    endfunction

    // Reference results computed with 64-bit integer arithmetic
    function automatic word_t model_result(input mdu_op_t op, input word_t a, input word_t b);
        longint      sa;
        longint      sb;
        longint      sprod;
        logic [63:0] uprod;
        word_t       res;
        sa    = $signed(a);
        sb    = $signed(b);
        sprod = sa * sb;
        uprod = {32'd0, a} * {32'd0, b};
        case (op)
            `MDU_OP_MUL:   res = uprod[31:0];
            `MDU_OP_MULH:  res = sprod[63:32];
            `MDU_OP_MULHU: res = uprod[63:32];
            `MDU_OP_DIV:   res = (b == 0) ? 32'hffff_ffff : word_t'(sa / sb);
            `MDU_OP_DIVU:  res = (b == 0) ? 32'hffff_ffff : a / b;
            `MDU_OP_MOD:   res = (b == 0) ? a : word_t'(sa % sb);
            `MDU_OP_MODU:  res = (b == 0) ? a : a % b;
            default:       res = '0;
        endcase
        return res;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "stopping after first error");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t: %s", $time, what);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping after timeout");
    endtask

    // Called on a falling edge; returns on a falling edge with ready_o high
    task automatic wait_ready();
        int unsigned cnt;
        cnt = 0;
        while (!ready_o) begin
            if (cnt >= WAIT_LIMIT) begin
                report_timeout("ready_o never rose to accept a request");
            end
            @(negedge clk);
            cnt++;
        end
    endtask

    task automatic scramble_inputs();
        logic [31:0] r;
        r       = next_rand();
        op_i    = r[2:0];
        src_a_i = next_rand();
        src_b_i = next_rand();
        info_i  = random_info();
    endtask

    // ==================================================================
    // One request through to its output transfer
    // ==================================================================

    task automatic run_request(input mdu_op_t op, input word_t a, input word_t b);
        mdu_info_t   info;
        int unsigned lat;
        int unsigned lat_expected;
        int unsigned hold;
        word_t       held_result;
        mdu_info_t   held_info;
        info = random_info();
        wait_ready();
        valid_i = 1'b1;
        op_i    = op;
        src_a_i = a;
        src_b_i = b;
        info_i  = info;
        exp_result_q.push_back(model_result(op, a, b));
        exp_info_q.push_back(info);
        @(posedge clk);
        @(negedge clk);
        valid_i = 1'b0;
        scramble_inputs();

        // Count cycles after the input transfer edge
        lat = 0;
        while (!valid_o) begin
            check_value("ready_o", 0, ready_o);
            if (lat >= WAIT_LIMIT) begin
                report_timeout("the result never arrived");
            end
            @(negedge clk);
            lat++;
        end
        lat_expected = (op == `MDU_OP_MUL || op == `MDU_OP_MULH || op == `MDU_OP_MULHU)
                     ? MUL_LAT : DIV_LAT;
        check_value("latency", lat_expected, lat);
        check_value("ready_o", 0, ready_o);

        // Outputs must hold under back-pressure
        hold        = next_rand() % 8;
        held_result = result_o;
        held_info   = info_o;
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            check_value("valid_o", 1, valid_o);
            check_value("result_o", held_result, result_o);
            check_value("info_o", held_info, info_o);
            check_value("ready_o", 0, ready_o);
        end

        check_value("result_o", exp_result_q.pop_front(), result_o);
        check_value("info_o", exp_info_q.pop_front(), info_o);
        ready_i = 1'b1;
        @(posedge clk);
        @(negedge clk);
        ready_i = 1'b0;
        check_value("valid_o", 0, valid_o);
        check_value("ready_o", 1, ready_o);
    endtask

    // Start a divide, then drop it with flush partway through
    task automatic flush_divide();
        logic [31:0] r;
        int unsigned delay;
        wait_ready();
        r       = next_rand();
        valid_i = 1'b1;
        op_i    = `MDU_OP_DIV + r[1:0];
        src_a_i = next_rand();
        src_b_i = next_rand();
        info_i  = random_info();
        @(posedge clk);
        @(negedge clk);
        valid_i = 1'b0;
        delay   = 2 + next_rand() % 25;
        repeat (delay) @(negedge clk);
        check_value("valid_o", 0, valid_o);
        flush_i = 1'b1;
        @(negedge clk);
        flush_i = 1'b0;
        check_value("ready_o", 1, ready_o);
        for (int i = 0; i < DIV_LAT + 8; i++) begin
            check_value("valid_o", 0, valid_o);
            check_value("ready_o", 1, ready_o);
            @(negedge clk);
        end
    endtask

    // ==================================================================
    // Stimulus
    // ==================================================================

    initial begin
        logic [31:0] r;
        word_t       a;
        word_t       b;
        clk         = 1'b0;
        rst_i       = 1'b1;
        flush_i     = 1'b0;
        valid_i     = 1'b0;
        ready_i     = 1'b0;
        op_i        = '0;
        src_a_i     = '0;
        src_b_i     = '0;
        info_i      = '0;
        rng_state   = 32'heb3;

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        @(negedge clk);
        check_value("valid_o", 0, valid_o);
        check_value("ready_o", 1, ready_o);

        // Multiply corners
        run_request(`MDU_OP_MULH, 32'h8000_0000, 32'h8000_0000);
        run_request(`MDU_OP_MULHU, 32'hffff_ffff, 32'hffff_ffff);
        run_request(`MDU_OP_MULH, 32'hffff_ffff, 32'h7fff_ffff);
        run_request(`MDU_OP_MUL, 32'hffff_ffff, 32'h8000_0001);

        for (int i = 0; i < 300; i++) begin
            r = next_rand();
            a = next_rand();
            b = next_rand();
            run_request(mdu_op_t'(r % 3), a, b);
        end

        // Division corners
        run_request(`MDU_OP_DIV, 32'h0000_007b, 32'h0);
        run_request(`MDU_OP_MOD, 32'hdead_beef, 32'h0);
        run_request(`MDU_OP_DIVU, 32'h8765_4321, 32'h0);
        run_request(`MDU_OP_MODU, 32'h8765_4321, 32'h0);
        run_request(`MDU_OP_DIV, 32'h8000_0000, 32'hffff_ffff);
        run_request(`MDU_OP_MOD, 32'h8000_0000, 32'hffff_ffff);

        for (int i = 0; i < 300; i++) begin
            r = next_rand();
            a = next_rand();
            b = next_rand();
            // Shrink the divisor often so quotients are not mostly 0 or 1
            if (r[4:3] != 2'b00) begin
                b = b >> r[9:5];
            end
            if (r[10]) begin
                b = -b;
            end
            run_request(mdu_op_t'(`MDU_OP_DIV + r[1:0]), a, b);
        end

        flush_divide();
        run_request(`MDU_OP_DIV, 32'hffff_ff85, 32'h0000_0007);
        flush_divide();
        run_request(`MDU_OP_MULH, 32'h9abc_def0, 32'h1234_5678);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- verilog/mdu.sv
`timescale 1ns/10ps
`include "mdu_defines.svh"

module mdu
    import mdu_pkg::*;
#(
    parameter type info_t = mdu_info_t
) (
    input  logic    clk,
    input  logic    rst_i,
    input  logic    flush_i,

    input  logic    valid_i,
    output logic    ready_o,
    input  mdu_op_t op_i,
    input  word_t   src_a_i,
    input  word_t   src_b_i,
    input  info_t   info_i,

    output logic    valid_o,
    input  logic    ready_i,
    output word_t   result_o,
    output info_t   info_o
);

    logic in_xfer;
    logic out_xfer;
    logic req_is_mul;

    logic    busy_q;
    logic    is_mul_q;
    logic    mul_start_q;
    logic    div_start_q;
    mdu_op_t op_q;
    word_t   src_a_q;
    word_t   src_b_q;
    info_t   info_q;

    logic  mul_done;
    logic  div_done;
    logic  mul_ack;
    logic  div_ack;
    word_t mul_result;
    word_t div_result;

    // ==================================================================
    // Request side
    // ==================================================================

    // One operation in flight, so accept only when nothing is pending
    assign ready_o = ~busy_q;
    assign in_xfer = valid_i & ready_o;

    assign req_is_mul = (op_i == `MDU_OP_MUL)
                     || (op_i == `MDU_OP_MULH)
                     || (op_i == `MDU_OP_MULHU);

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            busy_q      <= 1'b0;
            is_mul_q    <= 1'b0;
            mul_start_q <= 1'b0;
            div_start_q <= 1'b0;
        end else begin
            mul_start_q <= in_xfer & req_is_mul;
            div_start_q <= in_xfer & ~req_is_mul;
            if (in_xfer) begin
                busy_q   <= 1'b1;
                is_mul_q <= req_is_mul;
            end else if (out_xfer) begin
                busy_q <= 1'b0;
            end
        end
    end

    // Operands stay put for the engine's setup cycle
    always_ff @(posedge clk) begin
        if (in_xfer) begin
            op_q    <= op_i;
            src_a_q <= src_a_i;
            src_b_q <= src_b_i;
            info_q  <= info_i;
        end
    end

    // ==================================================================
    // Engines
    // ==================================================================

    mdu_multiplier u_multiplier (
        .clk      (clk),
        .rst_i    (rst_i),
        .flush_i  (flush_i),
        .start_i  (mul_start_q),
        .op_i     (op_q),
        .src_a_i  (src_a_q),
        .src_b_i  (src_b_q),
        .ack_i    (mul_ack),
        .done_o   (mul_done),
        .result_o (mul_result)
    );

    mdu_divider u_divider (
        .clk      (clk),
        .rst_i    (rst_i),
        .flush_i  (flush_i),
        .start_i  (div_start_q),
        .op_i     (op_q),
        .src_a_i  (src_a_q),
        .src_b_i  (src_b_q),
        .ack_i    (div_ack),
        .done_o   (div_done),
        .result_o (div_result)
    );

    // ==================================================================
    // Result side
    // ==================================================================

    assign valid_o  = is_mul_q ? mul_done : div_done;
    assign result_o = is_mul_q ? mul_result : div_result;
    assign info_o   = info_q;

    assign out_xfer = valid_o & ready_i;

    // Ack only the engine that produced the result
    assign mul_ack = out_xfer & is_mul_q;
    assign div_ack = out_xfer & ~is_mul_q;

endmodule

//--- verilog/mdu_defines.svh
`ifndef MDU_DEFINES_SVH
`define MDU_DEFINES_SVH

// ======================================================================
// Datapath sizing
// ======================================================================

`define MDU_XLEN        32

// One restoring step per quotient bit
`define MDU_DIV_STEPS   `MDU_XLEN

// ======================================================================
// Operation encodings
// ======================================================================

`define MDU_OP_MUL      3'd0
`define MDU_OP_MULH     3'd1
`define MDU_OP_MULHU    3'd2
`define MDU_OP_DIV      3'd3
`define MDU_OP_DIVU     3'd4
`define MDU_OP_MOD      3'd5
`define MDU_OP_MODU     3'd6

`endif

//--- verilog/mdu_divider.sv
`timescale 1ns/10ps
`include "mdu_defines.svh"

module mdu_divider
    import mdu_pkg::*;
(
    input  logic    clk,
    input  logic    rst_i,
    input  logic    flush_i,
    input  logic    start_i,
    input  mdu_op_t op_i,
    input  word_t   src_a_i,
    input  word_t   src_b_i,
    input  logic    ack_i,
    output logic    done_o,
    output word_t   result_o
);

    localparam int XLEN  = `MDU_XLEN;
    localparam int STEPS = `MDU_DIV_STEPS;
    localparam int CNTW  = $clog2(STEPS + 1);

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_FIX,
        DIV_DONE
    } div_state_e;

    div_state_e      state_q;
    logic [CNTW-1:0] count_q;

    // ==================================================================
    // Setup: signs, magnitudes and the zero-divisor flag
    // ==================================================================

    logic  op_signed;
    logic  op_rem;
    logic  a_neg;
    logic  b_neg;
    word_t a_abs;
    word_t b_abs;

    assign op_signed = (op_i == `MDU_OP_DIV) || (op_i == `MDU_OP_MOD);
    assign op_rem    = (op_i == `MDU_OP_MOD) || (op_i == `MDU_OP_MODU);
    assign a_neg     = op_signed & src_a_i[XLEN-1];
    assign b_neg     = op_signed & src_b_i[XLEN-1];
    assign a_abs     = a_neg ? -src_a_i : src_a_i;
    assign b_abs     = b_neg ? -src_b_i : src_b_i;

    logic  neg_quot_q;
    logic  neg_rem_q;
    logic  div_zero_q;
    logic  sel_rem_q;
    word_t divisor_q;
    word_t rem_q;
    word_t quot_q;

    // ==================================================================
    // Restoring step
    // ==================================================================

    logic [XLEN:0]   shifted;
    logic [XLEN+1:0] diff;
    logic            fits;

    // Dividend bits shift out of the quotient register into the remainder
    assign shifted = {rem_q, quot_q[XLEN-1]};
    assign diff    = {1'b0, shifted} - {2'b00, divisor_q};
    assign fits    = ~diff[XLEN+1];

    // Fixup values
    word_t quot_fix;
    word_t rem_fix;

    // A zero divisor leaves the remainder equal to the dividend by itself
    assign quot_fix = div_zero_q ? '1 : (neg_quot_q ? -quot_q : quot_q);
    assign rem_fix  = neg_rem_q ? -rem_q : rem_q;

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            state_q <= DIV_IDLE;
            count_q <= '0;
        end else begin
            case (state_q)
                DIV_IDLE: begin
                    if (start_i) begin
                        state_q <= DIV_RUN;
                        count_q <= CNTW'(STEPS);
                    end
                end
                DIV_RUN: begin
                    count_q <= count_q - 1'b1;
                    if (count_q == CNTW'(1)) begin
                        state_q <= DIV_FIX;
                    end
                end
                DIV_FIX: begin
                    state_q <= DIV_DONE;
                end
                DIV_DONE: begin
                    if (ack_i) begin
                        state_q <= DIV_IDLE;
                    end
                end
                default: begin
                    state_q <= DIV_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == DIV_IDLE && start_i) begin
            neg_quot_q <= a_neg ^ b_neg;
            neg_rem_q  <= a_neg;
            div_zero_q <= (src_b_i == '0);
            sel_rem_q  <= op_rem;
            divisor_q  <= b_abs;
            rem_q      <= '0;
            quot_q     <= a_abs;
        end else if (state_q == DIV_RUN) begin
            if (fits) begin
                rem_q <= diff[XLEN-1:0];
            end else begin
                rem_q <= shifted[XLEN-1:0];
            end
            quot_q <= {quot_q[XLEN-2:0], fits};
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == DIV_FIX) begin
            result_o <= sel_rem_q ? rem_fix : quot_fix;
        end
    end

    assign done_o = (state_q == DIV_DONE);

endmodule

//--- verilog/mdu_multiplier.sv
`timescale 1ns/10ps
`include "mdu_defines.svh"

module mdu_multiplier
    import mdu_pkg::*;
(
    input  logic    clk,
    input  logic    rst_i,
    input  logic    flush_i,
    input  logic    start_i,
    input  mdu_op_t op_i,
    input  word_t   src_a_i,
    input  word_t   src_b_i,
    input  logic    ack_i,
    output logic    done_o,
    output word_t   result_o
);

    localparam int XLEN = `MDU_XLEN;
    localparam int HALF = XLEN / 2;
    localparam int PPW  = 2 * HALF + 2;
    localparam int SUMW = 2 * XLEN + 2;

    // ==================================================================
    // Stage one: extend operands and form partial products
    // ==================================================================

    logic                  ext_signed;
    logic signed [XLEN:0]  a_ext;
    logic signed [XLEN:0]  b_ext;
    logic signed [HALF:0]  a_hi;
    logic signed [HALF:0]  a_lo;
    logic signed [HALF:0]  b_hi;
    logic signed [HALF:0]  b_lo;

    // Only MULH treats operands as signed; MUL's low word is sign agnostic
    assign ext_signed = (op_i == `MDU_OP_MULH);
    assign a_ext      = {ext_signed & src_a_i[XLEN-1], src_a_i};
    assign b_ext      = {ext_signed & src_b_i[XLEN-1], src_b_i};

    // Upper halves keep the sign, lower halves are plain magnitudes
    assign a_hi = a_ext[XLEN:HALF];
    assign b_hi = b_ext[XLEN:HALF];
    assign a_lo = {1'b0, a_ext[HALF-1:0]};
    assign b_lo = {1'b0, b_ext[HALF-1:0]};

    logic                  s1_valid_q;
    logic                  hi_sel_q;
    logic signed [PPW-1:0] pp_ll_q;
    logic signed [PPW-1:0] pp_lh_q;
    logic signed [PPW-1:0] pp_hl_q;
    logic signed [PPW-1:0] pp_hh_q;

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            s1_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= start_i;
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            pp_ll_q  <= a_lo * b_lo;
            pp_lh_q  <= a_lo * b_hi;
            pp_hl_q  <= a_hi * b_lo;
            pp_hh_q  <= a_hi * b_hi;
            hi_sel_q <= (op_i != `MDU_OP_MUL);
        end
    end

    // ==================================================================
    // Stage two: accumulate and pick a word
    // ==================================================================

    logic signed [SUMW-1:0] ll_ext;
    logic signed [SUMW-1:0] lh_ext;
    logic signed [SUMW-1:0] hl_ext;
    logic signed [SUMW-1:0] hh_ext;
    logic signed [SUMW-1:0] sum;
    dword_t                 product;

    assign ll_ext = pp_ll_q;
    assign lh_ext = pp_lh_q;
    assign hl_ext = pp_hl_q;
    assign hh_ext = pp_hh_q;

    assign sum     = (hh_ext <<< (2 * HALF)) + ((lh_ext + hl_ext) <<< HALF) + ll_ext;
    assign product = sum[2*XLEN-1:0];

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            done_o <= 1'b0;
        end else if (s1_valid_q) begin
            done_o <= 1'b1;
        end else if (ack_i) begin
            done_o <= 1'b0;
        end
    end

    // Held until the next operation reaches stage two
    always_ff @(posedge clk) begin
        if (s1_valid_q) begin
            result_o <= hi_sel_q ? product[2*XLEN-1:XLEN] : product[XLEN-1:0];
        end
    end

endmodule

//--- verilog/mdu_pkg.sv
`include "mdu_defines.svh"

package mdu_pkg;

    // One register-file word
    typedef logic [`MDU_XLEN-1:0] word_t;

    // Full-width product
    typedef logic [2*`MDU_XLEN-1:0] dword_t;

    typedef logic [2:0] mdu_op_t;

    // Decode info carried alongside a request
    typedef struct packed {
        logic [4:0] rd;
        word_t      pc;
        logic       we;
    } mdu_info_t;

endpackage
